/* compile.f */
logic/core_pkg.sv
logic/inst_decode.sv
logic/alu_execute.sv
logic/result_regfile.sv
logic/core.sv
tests/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SRCS      ?= $(wildcard logic/*.sv tests/*.sv)

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx 'sim passed' $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    // cycle of addr_o to cycle of the retire, memory read included
    localparam int RETIRE_LAT = 4;
    localparam int IMEM_DEPTH = 1 << IMEM_ADDR_W;

    typedef struct packed {
        logic [IMEM_ADDR_W-1:0] addr;
        logic                   lane;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        value;
    } expect_t;

    logic                   clock_i;
    logic                   rst_n_i;
    logic [FETCH_W-1:0]     data_i;
    logic [IMEM_ADDR_W-1:0] addr_o;
    exec_lane_t             retire_0_o;
    exec_lane_t             retire_1_o;

    logic [FETCH_W-1:0] mem [IMEM_DEPTH];
    logic [XLEN-1:0]    model_rf [NUM_REGS];
    logic [31:0]        prog [$];
    expect_t            exp_q [$];
    string              test_name;
    int                 cycle_cnt;
    int                 budget_cycles;
    int                 err_cnt;
    int                 check_cnt;
    int                 tests_run;
    int                 tests_failed;

    core dut0 (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .data_i     (data_i),
        .addr_o     (addr_o),
        .retire_0_o (retire_0_o),
        .retire_1_o (retire_1_o)
    );

    always #4 clock_i = ~clock_i;

    // synchronous instruction memory
    always @(posedge clock_i) begin
        data_i <= mem[addr_o];
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), OPC_LUI};
    endfunction

    // upper part rounded so the sign-extended addi lands on value
    task automatic load_reg(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(enc_lui(rd, upper[31:12]));
        prog.push_back(enc_i(F3_ADD, rd, rd, value[11:0]));
    endtask

    // RV32I semantics of one word against the model registers
    function automatic logic model_exec(input logic [31:0] w, output logic [XLEN-1:0] val);
        logic [6:0]      opc;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            alt;
        logic            ok;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        alt = (f7 == F7_ALT);
        a   = model_rf[w[19:15]];
        b   = (opc == OPC_OP) ? model_rf[w[24:20]] : {{20{w[31]}}, w[31:20]};
        val = '0;
        if (opc == OPC_LUI) begin
            val = {w[31:12], 12'h000};
            return 1'b1;
        end
        if (opc == OPC_OP) begin
            ok = (f7 == F7_BASE) || (alt && (f3 == F3_ADD || f3 == F3_SR));
        end else if (opc == OPC_OP_IMM && f3 == F3_SLL) begin
            ok = (f7 == F7_BASE);
        end else if (opc == OPC_OP_IMM && f3 == F3_SR) begin
            ok = (f7 == F7_BASE) || alt;
        end else begin
            ok = (opc == OPC_OP_IMM);
        end
        case (f3)
            F3_ADD:  val = (opc == OPC_OP && alt) ? a - b : a + b;
            F3_SLL:  val = a << b[4:0];
            F3_SLT:  val = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: val = {31'b0, a < b};
            F3_XOR:  val = a ^ b;
            F3_SR: begin
                if (alt) begin
                    val = $signed(a) >>> b[4:0];
                end else begin
                    val = a >> b[4:0];
                end
            end
            F3_OR:   val = a | b;
            default: val = a & b;
        endcase
        return ok;
    endfunction

    // in order, lane 0 before lane 1
    task automatic build_expect(input int npairs);
        expect_t         e;
        logic [XLEN-1:0] val;
        logic [31:0]     w;
        for (int p = 0; p < npairs; p++) begin
            for (int lane = 0; lane < 2; lane++) begin
                w = prog[2*p + lane];
                if (model_exec(w, val)) begin
                    e.addr  = IMEM_ADDR_W'(p);
                    e.lane  = lane[0];
                    e.rd    = w[11:7];
                    e.value = val;
                    exp_q.push_back(e);
                    if (w[11:7] != '0) begin
                        model_rf[w[11:7]] = val;
                    end
                end
            end
        end
    endtask

    task automatic check_retire(input int lane, input exec_lane_t r);
        expect_t e;
        if (!r.valid) begin
            return;
        end
        assert (exp_q.size() > 0) else begin
            $display("%s: lane %0d retired x%0d with nothing outstanding", test_name, lane, r.rd);
            err_cnt++;
        end
        if (exp_q.size() == 0) begin
            return;
        end
        e = exp_q.pop_front();
        check_cnt++;
        assert (int'(e.addr) == cycle_cnt - RETIRE_LAT && int'(e.lane) == lane) else begin
            $display("error %s: lane %0d pair %0d expected, lane %0d pair %0d actual",
                     test_name, e.lane, e.addr, lane, cycle_cnt - RETIRE_LAT);
            err_cnt++;
        end
        assert (r.rd == e.rd && r.value == e.value) else begin
            $display("error %s: x%0d = %h expected, x%0d = %h actual",
                     test_name, e.rd, e.value, r.rd, r.value);
            err_cnt++;
        end
    endtask

    // sampled mid-cycle, away from the edges
    always @(negedge clock_i) begin
        if (!rst_n_i) begin
            cycle_cnt = 0;
        end else begin
            assert (addr_o == IMEM_ADDR_W'(cycle_cnt)) else begin
                $display("error %s: addr_o expected %0d actual %0d", test_name, cycle_cnt, addr_o);
                err_cnt++;
            end
            check_retire(0, retire_0_o);
            check_retire(1, retire_1_o);
            cycle_cnt++;
        end
    end

    task automatic run_prog(input string name);
        int npairs;
        int err_before;
        if (prog.size() % 2 != 0) begin
            prog.push_back(32'h0);
        end
        npairs = prog.size() / 2;
        budget_cycles += npairs + 20;
        test_name  = name;
        err_before = err_cnt;
        @(posedge clock_i);
        rst_n_i <= 1'b0;
        @(posedge clock_i);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            mem[a] = '0;
        end
        for (int p = 0; p < npairs; p++) begin
            mem[p] = {prog[2*p + 1], prog[2*p]};
        end
        build_expect(npairs);
        repeat (3) @(posedge clock_i);
        rst_n_i <= 1'b1;
        repeat (npairs + RETIRE_LAT + 2) @(posedge clock_i);
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected retires never appeared", name, exp_q.size());
            err_cnt++;
        end
        exp_q.delete();
        prog.delete();
        tests_run++;
        if (err_cnt != err_before) begin
            tests_failed++;
        end
        $display("test %s: %0d pairs, %0d errors", name, npairs, err_cnt - err_before);
    endtask

    task automatic test_fetch_timing();
        for (int p = 0; p < 6; p++) begin
            prog.push_back(enc_i(F3_ADD, 2*p + 1, 0, 12'(3*p + 1)));
            prog.push_back(enc_i(F3_OR, 2*p + 2, 0, 12'(12'h100 + p)));
        end
        run_prog("fetch_timing");
    endtask

    task automatic test_imm_ops();
        prog.push_back(enc_lui(1, 20'habcde));
        prog.push_back(enc_lui(2, 20'h80001));
        prog.push_back(enc_i(F3_ADD, 3, 0, 12'hb2e));
        prog.push_back(enc_i(F3_OR, 4, 0, 12'h7ff));
        prog.push_back(enc_i(F3_XOR, 5, 0, 12'hfff));
        prog.push_back(enc_i(F3_AND, 6, 0, 12'h055));
        prog.push_back(enc_i(F3_SLT, 7, 0, 12'h001));
        prog.push_back(enc_i(F3_SLTU, 8, 0, 12'hfff));
        prog.push_back(enc_i(F3_SLL, 9, 1, 12'h004));
        prog.push_back(enc_i(F3_SR, 10, 2, 12'h01f));
        // srai
        prog.push_back(enc_i(F3_SR, 11, 2, 12'h407));
        prog.push_back(enc_i(F3_SLT, 12, 3, 12'h800));
        run_prog("imm_ops");
    endtask

    task automatic test_reg_ops();
        load_reg(1, $urandom());
        load_reg(2, $urandom());
        load_reg(3, $urandom() | 32'h8000_0000);
        load_reg(4, $urandom() & 32'h7fff_ffff);
        load_reg(5, 32'd31);
        load_reg(6, $urandom() | 32'h0000_0020);
        prog.push_back(enc_r(F7_BASE, F3_ADD, 20, 1, 2));
        prog.push_back(enc_r(F7_ALT, F3_ADD, 21, 1, 2));
        prog.push_back(enc_r(F7_BASE, F3_AND, 22, 1, 2));
        prog.push_back(enc_r(F7_BASE, F3_OR, 23, 1, 2));
        prog.push_back(enc_r(F7_BASE, F3_XOR, 24, 1, 2));
        prog.push_back(enc_r(F7_BASE, F3_SLL, 25, 3, 5));
        prog.push_back(enc_r(F7_BASE, F3_SR, 26, 3, 5));
        prog.push_back(enc_r(F7_ALT, F3_SR, 27, 3, 5));
        prog.push_back(enc_r(F7_BASE, F3_SLL, 28, 1, 6));
        prog.push_back(enc_r(F7_BASE, F3_SR, 29, 3, 6));
        prog.push_back(enc_r(F7_ALT, F3_SR, 30, 3, 6));
        prog.push_back(enc_r(F7_BASE, F3_SLT, 31, 3, 4));
        prog.push_back(enc_r(F7_BASE, F3_SLTU, 20, 3, 4));
        prog.push_back(enc_r(F7_BASE, F3_SLT, 21, 4, 3));
        prog.push_back(enc_r(F7_BASE, F3_SLTU, 22, 4, 3));
        prog.push_back(enc_r(F7_BASE, F3_SLT, 23, 1, 2));
        prog.push_back(enc_r(F7_BASE, F3_SLTU, 24, 1, 2));
        run_prog("reg_ops");
    endtask

    task automatic test_forwarding();
        load_reg(7, $urandom());
        load_reg(8, $urandom());
        for (int i = 0; i < 8; i++) begin
            // lane 0 reads both lanes of the pair before, lane 1 chains on lane 0
            prog.push_back(enc_r(($urandom_range(1) != 0) ? F7_ALT : F7_BASE, F3_ADD, 7, 8, 7));
            prog.push_back(enc_r(F7_BASE, (i % 2 != 0) ? F3_XOR : F3_ADD, 8, 7, 8));
        end
        prog.push_back(enc_i(F3_XOR, 12, 8, 12'($urandom())));
        prog.push_back(enc_r(F7_ALT, F3_ADD, 13, 7, 12));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(enc_r(F7_BASE, F3_XOR, 9, 7, 8));
        prog.push_back(enc_r(F7_ALT, F3_ADD, 10, 13, 9));
        run_prog("forwarding");
    endtask

    task automatic test_x0_and_invalid();
        prog.push_back(enc_i(F3_ADD, 0, 0, 12'h005));
        prog.push_back(enc_r(F7_BASE, F3_ADD, 12, 0, 0));
        prog.push_back(enc_i(F3_ADD, 13, 0, 12'h001));
        prog.push_back(enc_i(F3_ADD, 13, 0, 12'h002));
        prog.push_back(enc_r(F7_BASE, F3_ADD, 14, 13, 0));
        prog.push_back(32'hffff_ffff);
        prog.push_back(32'h0000_0000);
        // lw x1, 0(x0)
        prog.push_back(32'h0000_2083);
        prog.push_back(enc_r(F7_BASE, F3_OR, 15, 13, 0));
        prog.push_back(enc_r(F7_ALT, F3_AND, 16, 13, 13));
        prog.push_back(enc_i(F3_SLL, 17, 13, 12'h401));
        prog.push_back(enc_i(F3_SR, 18, 13, 12'h401));
        prog.push_back(enc_r(F7_BASE, F3_ADD, 19, 0, 13));
        run_prog("x0_and_invalid");
    endtask

    // ends the run once the tests outlast their cycle budget
    initial begin
        int elapsed;
        elapsed = 0;
        while (elapsed <= budget_cycles) begin
            @(posedge clock_i);
            elapsed++;
        end
        $display("timeout: tests still running after %0d cycles", elapsed);
        $display("sim failed");
        $finish;
    end

    initial begin
        clock_i = 1'b0;
        rst_n_i <= 1'b0;
        data_i  <= '0;
        void'($urandom(32'h5fe4_bece));
        for (int r = 0; r < NUM_REGS; r++) begin
            model_rf[r] = '0;
        end
        test_fetch_timing();
        test_imm_ops();
        test_reg_ops();
        test_forwarding();
        test_x0_and_invalid();
        $display("%0d tests, %0d failed, %0d retires checked, %0d errors",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* logic/core.sv */
`timescale 1ns/1ps

module core import core_pkg::*; (
    input  logic                    clock_i,
    input  logic                    rst_n_i,
    input  logic [FETCH_W-1:0]      data_i,
    output logic [IMEM_ADDR_W-1:0]  addr_o,
    output exec_lane_t              retire_0_o,
    output exec_lane_t              retire_1_o
);

    // byte address of the fetch pair
    logic [IMEM_ADDR_W+FETCH_LSB-1:0] fetch_pc_q;
    logic                             fetch_valid_q;

    dec_lane_t                   dec_0;
    dec_lane_t                   dec_1;
    exec_lane_t                  exe_0;
    exec_lane_t                  exe_1;
    exec_lane_t                  res_0;
    exec_lane_t                  res_1;
    logic [3:0][REG_ADDR_W-1:0]  rs_addr;
    logic [3:0][XLEN-1:0]        rs_data;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_pc_q    <= '0;
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_pc_q    <= fetch_pc_q + (IMEM_ADDR_W+FETCH_LSB)'(FETCH_STEP);
            // memory answers one cycle after the first address
            fetch_valid_q <= 1'b1;
        end
    end

    assign addr_o = fetch_pc_q[FETCH_LSB +: IMEM_ADDR_W];

    inst_decode dec0 (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_q),
        .data_i         (data_i),
        .dec_0_o        (dec_0),
        .dec_1_o        (dec_1)
    );

    alu_execute exe0 (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .dec_0_i        (dec_0),
        .dec_1_i        (dec_1),
        .rs_addr_o      (rs_addr),
        .rs_data_i      (rs_data),
        .fwd_0_i        (res_0),
        .fwd_1_i        (res_1),
        .exe_0_o        (exe_0),
        .exe_1_o        (exe_1)
    );

    result_regfile res0 (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .exe_0_i        (exe_0),
        .exe_1_i        (exe_1),
        .rs_addr_i      (rs_addr),
        .rs_data_o      (rs_data),
        .res_0_o        (res_0),
        .res_1_o        (res_1)
    );

    assign retire_0_o = res_0;
    assign retire_1_o = res_1;

endmodule

/* logic/result_regfile.sv */
`timescale 1ns/1ps

module result_regfile import core_pkg::*; (
    input  logic                        clock_i,
    input  logic                        rst_n_i,
    input  exec_lane_t                  exe_0_i,
    input  exec_lane_t                  exe_1_i,
    input  logic [3:0][REG_ADDR_W-1:0]  rs_addr_i,
    output logic [3:0][XLEN-1:0]        rs_data_o,
    output exec_lane_t                  res_0_o,
    output exec_lane_t                  res_1_o
);

    logic [XLEN-1:0] rf_q [NUM_REGS];
    exec_lane_t      res_q [2];
    logic [1:0]      valid_q;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {exe_1_i.valid, exe_0_i.valid};
        end
    end

    always_ff @(posedge clock_i) begin
        res_q[0] <= exe_0_i;
        res_q[1] <= exe_1_i;
    end

    always_comb begin
        res_0_o       = res_q[0];
        res_0_o.valid = valid_q[0];
        res_1_o       = res_q[1];
        res_1_o.valid = valid_q[1];
    end

    // lane 1 written last so it wins on the same rd
    always_ff @(posedge clock_i) begin
        if (res_0_o.valid && res_0_o.rd != '0) begin
            rf_q[res_0_o.rd] <= res_0_o.value;
        end
        if (res_1_o.valid && res_1_o.rd != '0) begin
            rf_q[res_1_o.rd] <= res_1_o.value;
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rs_data_o[k] = (rs_addr_i[k] == '0) ? '0 : rf_q[rs_addr_i[k]];
        end
    end

    a_x0_untouched: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ((res_0_o.valid && res_0_o.rd == '0) || (res_1_o.valid && res_1_o.rd == '0))
        |=> rf_q[0] === $past(rf_q[0]));

endmodule

/* logic/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import core_pkg::*; (
    input  logic                             clock_i,
    input  logic                             rst_n_i,
    input  dec_lane_t                        dec_0_i,
    input  dec_lane_t                        dec_1_i,
    output logic [3:0][REG_ADDR_W-1:0]       rs_addr_o,
    input  logic [3:0][XLEN-1:0]             rs_data_i,
    input  exec_lane_t                       fwd_0_i,
    input  exec_lane_t                       fwd_1_i,
    output exec_lane_t                       exe_0_o,
    output exec_lane_t                       exe_1_o
);

    logic [XLEN-1:0] rs1_0;
    logic [XLEN-1:0] rs2_0;
    logic [XLEN-1:0] rs1_1;
    logic [XLEN-1:0] rs2_1;
    exec_lane_t      exe_d [2];
    exec_lane_t      exe_q [2];
    logic [1:0]      valid_q;

    // take src when it targets idx, else keep the older value
    function automatic logic [XLEN-1:0] newer(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       older_val,
        input exec_lane_t            src
    );
        if (src.valid && idx != '0 && src.rd == idx) begin
            return src.value;
        end
        return older_val;
    endfunction

    function automatic logic [XLEN-1:0] operand(
        input logic [REG_ADDR_W-1:0] idx,
        input logic [XLEN-1:0]       rf_val,
        input exec_lane_t            f0,
        input exec_lane_t            f1,
        input exec_lane_t            e0,
        input exec_lane_t            e1
    );
        if (idx == '0) begin
            return '0;
        end
        // previous pair sits in the execute register and beats the result stage
        return newer(idx, newer(idx, newer(idx, newer(idx, rf_val, f0), f1), e0), e1);
    endfunction

    function automatic logic [XLEN-1:0] alu(
        input dec_lane_t       d,
        input logic [XLEN-1:0] rs1_val,
        input logic [XLEN-1:0] rs2_val
    );
        logic [XLEN-1:0]         a;
        logic [XLEN-1:0]         b;
        logic [$clog2(XLEN)-1:0] shamt;
        logic [XLEN-1:0]         res;
        a     = d.use_rs1 ? rs1_val : '0;
        b     = d.use_imm ? d.imm : (d.use_rs2 ? rs2_val : '0);
        shamt = b[$clog2(XLEN)-1:0];
        case (d.alu_op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_SLL:  res = a << shamt;
            ALU_SRL:  res = a >> shamt;
            ALU_SRA:  res = $unsigned($signed(a) >>> shamt);
            ALU_SLT:  res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
            default:  res = '0;
        endcase
        return res;
    endfunction

    assign rs_addr_o = {dec_1_i.rs2, dec_1_i.rs1, dec_0_i.rs2, dec_0_i.rs1};

    always_comb begin
        rs1_0 = operand(dec_0_i.rs1, rs_data_i[0], fwd_0_i, fwd_1_i, exe_0_o, exe_1_o);
        rs2_0 = operand(dec_0_i.rs2, rs_data_i[1], fwd_0_i, fwd_1_i, exe_0_o, exe_1_o);

        exe_d[0].valid = dec_0_i.valid;
        exe_d[0].rd    = dec_0_i.rd;
        exe_d[0].value = alu(dec_0_i, rs1_0, rs2_0);

        // chained forward from lane 0 of the same pair
        rs1_1 = newer(dec_1_i.rs1,
                      operand(dec_1_i.rs1, rs_data_i[2], fwd_0_i, fwd_1_i,
                              exe_0_o, exe_1_o),
                      exe_d[0]);
        rs2_1 = newer(dec_1_i.rs2,
                      operand(dec_1_i.rs2, rs_data_i[3], fwd_0_i, fwd_1_i,
                              exe_0_o, exe_1_o),
                      exe_d[0]);

        exe_d[1].valid = dec_1_i.valid;
        exe_d[1].rd    = dec_1_i.rd;
        exe_d[1].value = alu(dec_1_i, rs1_1, rs2_1);
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {exe_d[1].valid, exe_d[0].valid};
        end
    end

    always_ff @(posedge clock_i) begin
        exe_q <= exe_d;
    end

    always_comb begin
        exe_0_o       = exe_q[0];
        exe_0_o.valid = valid_q[0];
        exe_1_o       = exe_q[1];
        exe_1_o.valid = valid_q[1];
    end

    a_valid_from_input: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ({exe_1_o.valid, exe_0_o.valid} & ~$past({dec_1_i.valid, dec_0_i.valid})) == 2'b00);

endmodule

/* logic/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import core_pkg::*; (
    input  logic                clock_i,
    input  logic                rst_n_i,
    input  logic                fetch_valid_i,
    input  logic [FETCH_W-1:0]  data_i,
    output dec_lane_t           dec_0_o,
    output dec_lane_t           dec_1_o
);

    inst_u [1:0] words;
    dec_lane_t   dec_d [2];
    dec_lane_t   dec_q [2];
    logic [1:0]  valid_q;

    function automatic alu_op_e alu_op_for(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic dec_lane_t decode_lane(input inst_u word, input logic live);
        dec_lane_t d;
        logic      alt;
        logic      legal;
        d        = '0;
        alt      = (word.r.funct7 == F7_ALT);
        legal    = 1'b0;
        d.rs1    = word.r.rs1;
        d.rs2    = word.r.rs2;
        d.rd     = word.r.rd;
        d.alu_op = alu_op_for(word.r.funct3, alt);
        case (word.r.opcode)
            OPC_OP: begin
                d.use_rs1 = 1'b1;
                d.use_rs2 = 1'b1;
                legal = (word.r.funct7 == F7_BASE) ||
                        (alt && (word.r.funct3 == F3_ADD || word.r.funct3 == F3_SR));
            end
            OPC_OP_IMM: begin
                d.use_rs1 = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = XLEN'($signed(word.i.imm12));
                case (word.i.funct3)
                    F3_SLL: legal = (word.r.funct7 == F7_BASE);
                    F3_SR:  legal = (word.r.funct7 == F7_BASE) || alt;
                    default: begin
                        // upper imm bits are not a funct7 here
                        legal    = 1'b1;
                        d.alu_op = alu_op_for(word.i.funct3, 1'b0);
                    end
                endcase
            end
            OPC_LUI: begin
                d.use_imm = 1'b1;
                d.imm     = {word.u.imm20, 12'b0};
                d.alu_op  = ALU_ADD;
                legal     = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        d.valid = live && legal;
        return d;
    endfunction

    // lane 0 is the low half and the older instruction
    assign words = data_i;

    always_comb begin
        dec_d[0] = decode_lane(words[0], fetch_valid_i);
        dec_d[1] = decode_lane(words[1], fetch_valid_i);
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {dec_d[1].valid, dec_d[0].valid};
        end
    end

    always_ff @(posedge clock_i) begin
        dec_q <= dec_d;
    end

    always_comb begin
        dec_0_o       = dec_q[0];
        dec_0_o.valid = valid_q[0];
        dec_1_o       = dec_q[1];
        dec_1_o.valid = valid_q[1];
    end

    a_imm_xor_rs2: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !(dec_0_o.valid && dec_0_o.use_imm && dec_0_o.use_rs2) &&
        !(dec_1_o.valid && dec_1_o.use_imm && dec_1_o.use_rs2));

endmodule

/* logic/core_pkg.sv */
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 1 << REG_ADDR_W;
    localparam int FETCH_W     = 64;
    localparam int FETCH_STEP  = 8;
    localparam int FETCH_LSB   = $clog2(FETCH_STEP);
    localparam int IMEM_ADDR_W = 10;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    // sub and sra
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } inst_u;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } dec_lane_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } exec_lane_t;

endpackage
